// ==== tb.f ====
rv_pkg.sv
rv_decode.sv
rv_regfile.sv
rv_alu.sv
rv_branch.sv
rv_mem_wb.sv
rv_core.sv
tb_clock.sv
tb_mem.sv
tb_top.sv

// ==== run.sh ====
#!/bin/sh
# build and run the RV32I core testbench with Verilator
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert --top-module tb_top -f tb.f -o tb_sim &&
  ./obj_dir/tb_sim || exit 1

// ==== tb_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_top import rv_pkg::*; ;

  localparam logic [31:0] end_loop   = 32'h0000_006f;  // jal x0, 0
  localparam int          run_cycles = 300;
  localparam int          num_runs   = 8;
  localparam int          limit_ns   = (16 + num_runs * (run_cycles + 6)) * 10 + 1000;

  logic        clk;
  logic        por;
  logic        rst_pulse;
  logic        reset;
  logic [31:0] imem_addr;
  logic [31:0] imem_data;
  logic [31:0] dmem_addr;
  logic [31:0] dmem_wdata;
  logic [31:0] dmem_rdata;
  logic        dmem_read;
  logic        dmem_write;
  logic [3:0]  dmem_wmask;

  logic [31:0] prog [$];
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  logic [3:0]  exp_mask [$];
  int          res_off;
  int          seed;

  assign reset = por | rst_pulse;

  tb_clock clock_i (.clk(clk), .por(por));

  tb_mem mem_i (
    .clk(clk), .clear(reset),
    .imem_addr(imem_addr), .imem_data(imem_data),
    .dmem_addr(dmem_addr), .dmem_read(dmem_read), .dmem_write(dmem_write),
    .dmem_wdata(dmem_wdata), .dmem_wmask(dmem_wmask), .dmem_rdata(dmem_rdata)
  );

  rv_core rv_core_i (
    .clk(clk), .reset(reset),
    .imem_data(imem_data), .dmem_rdata(dmem_rdata),
    .imem_addr(imem_addr), .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata),
    .dmem_read(dmem_read), .dmem_write(dmem_write), .dmem_wmask(dmem_wmask)
  );

  // instruction encoders
  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, op_r};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
  endfunction

  function automatic logic [31:0] lanes(input logic [3:0] m);
    return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
  endfunction

  // RV32I integer rules
  function automatic logic [31:0] alu_rule(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'd0, $signed(a) < $signed(b)};
      3'd3:    return {31'd0, a < b};
      3'd4:    return a ^ b;
      3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_rule(input logic [2:0] f3, input logic [31:0] a,
                                       input logic [31:0] b);
    case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return $signed(a) < $signed(b);
      3'd5:    return $signed(a) >= $signed(b);
      3'd6:    return a < b;
      default: return a >= b;
    endcase
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR t=%0t %s: got %h, expected %h", $time, name, got, exp);
      $display("TB FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic fail(input string msg);
    $display("%s at t=%0t", msg, $time);
    $display("TB FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic new_program();
    prog.delete();
    exp_addr.delete();
    exp_data.delete();
    exp_mask.delete();
    res_off = 32'h100;
  endtask

  task automatic emit(input logic [31:0] w);
    prog.push_back(w);
  endtask

  task automatic expect_store(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] mask);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
    exp_mask.push_back(mask);
  endtask

  // lui/addi pair with the lui part rounded for the signed low half
  task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
    logic [31:0] hi;
    hi = v + 32'h800;
    emit(enc_u(hi[31:12], rd, op_lui));
    emit(enc_i(v[11:0], rd, f3_add, rd, op_imm));
  endtask

  task automatic store_result(input logic [4:0] rs, input logic [31:0] value);
    emit(enc_s(12'(res_off), rs, 5'd0, f3_w));
    expect_store(32'(res_off), value, 4'hf);
    res_off += 4;
  endtask

  task automatic load_rom();
    emit(end_loop);
    if (prog.size() > 256) fail("program does not fit in the instruction ROM");
    for (int i = 0; i < 256; i++) begin
      mem_i.rom[i] = (i < prog.size()) ? prog[i] : end_loop;
    end
  endtask

  task automatic wait_end();
    int n;
    n = 0;
    while (imem_data !== end_loop) begin
      // read strobe only for loads
      check("dmem_read", 32'(dmem_read), 32'(imem_data[6:0] == op_load));
      @(negedge clk);
      n++;
      if (n > run_cycles) fail("program did not reach its end loop");
    end
  endtask

  task automatic run_program();
    @(posedge clk);
    #1 rst_pulse = 1'b1;
    load_rom();
    repeat (3) @(posedge clk);
    #1 rst_pulse = 1'b0;
    @(negedge clk);
    wait_end();
  endtask

  task automatic check_log();
    check("store count", 32'(mem_i.log_addr.size()), 32'(exp_addr.size()));
    for (int i = 0; i < exp_addr.size(); i++) begin
      check("dmem_addr", mem_i.log_addr[i], exp_addr[i]);
      check("dmem_wmask", 32'(mem_i.log_mask[i]), 32'(exp_mask[i]));
      check("dmem_wdata", mem_i.log_data[i] & lanes(exp_mask[i]),
            exp_data[i] & lanes(exp_mask[i]));
    end
  endtask

  task automatic reset_test();
    new_program();
    emit(enc_s(12'h600, 5'd0, 5'd0, f3_w));  // store held back by reset
    expect_store(32'h600, 32'h0, 4'hf);
    load_rom();
    do begin
      @(negedge clk);
      if (reset) begin
        check("dmem_write", 32'(dmem_write), 32'h0);
        check("imem_addr", imem_addr, reset_pc);
      end
    end while (reset);
    check("imem_addr", imem_addr, reset_pc);  // first fetch
    @(negedge clk);
    check("imem_addr", imem_addr, reset_pc + 32'd4);
    wait_end();
    check_log();
  endtask

  task automatic alu_test(input logic [31:0] a, input logic [31:0] b);
    logic [11:0] imm;
    logic        alt;
    new_program();
    load_const(5'd1, a);
    load_const(5'd2, b);
    for (int f = 0; f < 8; f++) begin
      for (int k = 0; k < 2; k++) begin
        alt = k[0];
        if (!alt || f == 0 || f == 5) begin
          emit(enc_r(alt ? 7'h20 : 7'h00, 5'd2, 5'd1, 3'(f), 5'd3));
          store_result(5'd3, alu_rule(3'(f), alt, a, b));
        end
      end
    end
    for (int f = 0; f < 8; f++) begin
      imm = 12'($random(seed));
      if (f == 1) imm = {7'h00, imm[4:0]};
      if (f == 5) imm = {1'b0, imm[10], 5'd0, imm[4:0]};  // srli or srai
      emit(enc_i(imm, 5'd1, 3'(f), 5'd3, op_imm));
      store_result(5'd3, alu_rule(3'(f), (f == 5) && imm[10], a, {{20{imm[11]}}, imm}));
    end
    run_program();
    check_log();
  endtask

  task automatic branch_test();
    logic [31:0] pa [4];
    logic [31:0] pb [4];
    logic [2:0]  f3;
    new_program();
    pa[0] = $random(seed);
    pb[0] = $random(seed);
    pa[1] = pa[0];
    pb[1] = pa[0];
    pa[2] = 32'h8000_0000;
    pb[2] = 32'h0000_0001;
    pa[3] = 32'hffff_ffff;
    pb[3] = 32'h0000_0000;
    for (int k = 0; k < 6; k++) begin
      f3 = (k < 2) ? 3'(k) : 3'(k + 2);
      for (int p = 0; p < 4; p++) begin
        load_const(5'd1, pa[p]);
        load_const(5'd2, pb[p]);
        emit(enc_b(13'd12, 5'd2, 5'd1, f3));
        emit(enc_i(12'd1, 5'd0, f3_add, 5'd3, op_imm));  // fall-through marker
        emit(enc_j(21'd8, 5'd0));
        emit(enc_i(12'd2, 5'd0, f3_add, 5'd3, op_imm));  // taken marker
        store_result(5'd3, branch_rule(f3, pa[p], pb[p]) ? 32'd2 : 32'd1);
      end
    end
    run_program();
    check_log();
  endtask

  task automatic jump_test();
    logic [19:0] u;
    u = 20'($random(seed));
    new_program();
    emit(enc_j(21'd8, 5'd5));                         // skips the next word
    emit(enc_s(12'h200, 5'd0, 5'd0, f3_w));
    emit(enc_s(12'h200, 5'd5, 5'd0, f3_w));
    expect_store(32'h200, reset_pc + 32'd4, 4'hf);
    emit(enc_u(u, 5'd6, op_auipc));
    emit(enc_s(12'h204, 5'd6, 5'd0, f3_w));
    expect_store(32'h204, reset_pc + 32'd12 + {u, 12'h000}, 4'hf);
    emit(enc_u(20'd0, 5'd8, op_auipc));
    emit(enc_i(12'd13, 5'd8, 3'd0, 5'd9, op_jalr));   // odd target lands on index 8
    emit(enc_s(12'h200, 5'd0, 5'd0, f3_w));
    emit(enc_s(12'h208, 5'd9, 5'd0, f3_w));
    expect_store(32'h208, reset_pc + 32'd28, 4'hf);
    emit(enc_u(20'd0, 5'd10, op_auipc));              // pc reached through jalr
    emit(enc_s(12'h20c, 5'd10, 5'd0, f3_w));
    expect_store(32'h20c, reset_pc + 32'd36, 4'hf);
    run_program();
    check_log();
  endtask

  task automatic store_test();
    logic [31:0] v;
    logic [31:0] addr;
    logic [31:0] rep;
    logic [3:0]  m;
    logic [2:0]  f3;
    int          off;
    v = $random(seed);
    new_program();
    load_const(5'd1, v);
    for (int w = 0; w < 7; w++) begin
      if (w < 4) begin
        f3 = f3_b;
        off = w;
        m = 4'b0001 << off;
        rep = {4{v[7:0]}};
      end else if (w < 6) begin
        f3 = f3_h;
        off = (w - 4) * 2;
        m = 4'b0011 << off;
        rep = {2{v[15:0]}};
      end else begin
        f3 = f3_w;
        off = 0;
        m = 4'b1111;
        rep = v;
      end
      addr = 32'h300 + 32'(4 * w + off);
      emit(enc_s(addr[11:0], 5'd1, 5'd0, f3));
      expect_store(addr, rep, m);
    end
    run_program();
    check_log();
    for (int i = 0; i < 7; i++) begin
      addr = 32'h300 + 32'(4 * i);
      check("ram word", mem_i.ram[addr[10:2]],
            (mem_i.fill_pattern(addr) & ~lanes(exp_mask[i])) |
            (exp_data[i] & lanes(exp_mask[i])));
    end
  endtask

  task automatic load_test();
    logic [31:0] v;
    logic [7:0]  bt;
    logic [15:0] hw;
    v = $random(seed);
    new_program();
    load_const(5'd1, v);
    emit(enc_s(12'h400, 5'd1, 5'd0, f3_w));
    expect_store(32'h400, v, 4'hf);
    for (int o = 0; o < 4; o++) begin
      bt = v[8*o +: 8];
      emit(enc_i(12'h400 + 12'(o), 5'd0, f3_b, 5'd2, op_load));
      store_result(5'd2, {{24{bt[7]}}, bt});
      emit(enc_i(12'h400 + 12'(o), 5'd0, f3_bu, 5'd2, op_load));
      store_result(5'd2, {24'd0, bt});
    end
    for (int o = 0; o < 4; o += 2) begin
      hw = v[8*o +: 16];
      emit(enc_i(12'h400 + 12'(o), 5'd0, f3_h, 5'd2, op_load));
      store_result(5'd2, {{16{hw[15]}}, hw});
      emit(enc_i(12'h400 + 12'(o), 5'd0, f3_hu, 5'd2, op_load));
      store_result(5'd2, {16'd0, hw});
    end
    emit(enc_i(12'h400, 5'd0, f3_w, 5'd2, op_load));
    store_result(5'd2, v);
    run_program();
    check_log();
  endtask

  initial begin
    #limit_ns;
    $display("watchdog expired before the tests completed");
    $display("TB FAILED");
    $fatal(1, "timeout");
  end

  initial begin
    seed = 32'hb3ce4eed;
    rst_pulse = 1'b0;
    reset_test();
    alu_test($random(seed), $random(seed));
    alu_test(32'h8000_0000, 32'hffff_ffff);  // sign edge cases
    alu_test($random(seed), $random(seed));
    branch_test();
    jump_test();
    store_test();
    load_test();
    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb_mem.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_mem import rv_pkg::*; (
  input  logic              clk,
  input  logic              clear,
  input  logic [xlen-1:0]   imem_addr,
  output logic [xlen-1:0]   imem_data,
  input  logic [xlen-1:0]   dmem_addr,
  input  logic              dmem_read,
  input  logic              dmem_write,
  input  logic [xlen-1:0]   dmem_wdata,
  input  logic [strb_w-1:0] dmem_wmask,
  output logic [xlen-1:0]   dmem_rdata
);

  logic [xlen-1:0]   rom [0:255];  // 1 KB at reset_pc
  logic [xlen-1:0]   ram [0:511];  // 2 KB at address 0
  logic [xlen-1:0]   log_addr [$];
  logic [xlen-1:0]   log_data [$];
  logic [strb_w-1:0] log_mask [$];

  // every bit of the word address takes part
  function automatic logic [xlen-1:0] fill_pattern(input logic [xlen-1:0] addr);
    return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]} ^ 32'h5a5a_c3c3;
  endfunction

  // outside the rom window the fetch sees a self-loop jal
  assign imem_data  = (imem_addr[31:10] == reset_pc[31:10]) ? rom[imem_addr[9:2]]
                                                            : 32'h0000_006f;
  assign dmem_rdata = dmem_read ? ram[dmem_addr[10:2]] : '0;

  always @(posedge clk) begin
    if (clear) begin
      for (int i = 0; i < 512; i++) begin
        ram[i] = fill_pattern(32'(i) << 2);
      end
      log_addr.delete();
      log_data.delete();
      log_mask.delete();
    end else if (dmem_write) begin
      for (int b = 0; b < strb_w; b++) begin
        if (dmem_wmask[b]) ram[dmem_addr[10:2]][8*b +: 8] = dmem_wdata[8*b +: 8];
      end
      log_addr.push_back(dmem_addr);  // every store is kept for the checker
      log_data.push_back(dmem_wdata);
      log_mask.push_back(dmem_wmask);
    end
  end

endmodule

`default_nettype wire

// ==== tb_clock.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
  output logic clk,
  output logic por
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 10 ns period
  end

  // power-on reset for 16 cycles, released just after an edge
  initial begin
    por = 1'b1;
    repeat (16) @(posedge clk);
    #1 por = 1'b0;
  end

endmodule

`default_nettype wire

// ==== rv_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_core import rv_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  logic [xlen-1:0]   imem_data,
  input  logic [xlen-1:0]   dmem_rdata,
  output logic [xlen-1:0]   imem_addr,
  output logic [xlen-1:0]   dmem_addr,
  output logic [xlen-1:0]   dmem_wdata,
  output logic              dmem_read,
  output logic              dmem_write,
  output logic [strb_w-1:0] dmem_wmask
);

  logic [reg_addr_w-1:0] rs1;
  logic [reg_addr_w-1:0] rs2;
  logic [reg_addr_w-1:0] rd;
  logic [xlen-1:0]       imm;
  logic [2:0]            funct3;
  logic                  alt_op;
  logic                  use_imm;
  logic                  use_pc;
  logic                  arith_only;
  logic                  is_branch;
  logic                  is_jal;
  logic                  is_jalr;
  logic                  mem_read;
  logic                  mem_write;
  logic                  reg_write;
  wb_sel_t               wb_sel;
  logic [xlen-1:0]       rs1_data;
  logic [xlen-1:0]       rs2_data;
  logic [xlen-1:0]       rd_data;
  logic [xlen-1:0]       alu_result;
  logic [xlen-1:0]       pc;
  logic [xlen-1:0]       link;
  logic [xlen-1:0]       target;

  rv_decode u_decode (
    .reset      (reset),
    .inst       (imem_data),
    .rs1        (rs1),
    .rs2        (rs2),
    .rd         (rd),
    .imm        (imm),
    .funct3     (funct3),
    .alt_op     (alt_op),
    .use_imm    (use_imm),
    .use_pc     (use_pc),
    .arith_only (arith_only),
    .is_branch  (is_branch),
    .is_jal     (is_jal),
    .is_jalr    (is_jalr),
    .mem_read   (mem_read),
    .mem_write  (mem_write),
    .reg_write  (reg_write),
    .wb_sel     (wb_sel)
  );

  rv_regfile u_regfile (
    .clk       (clk),
    .reg_write (reg_write),
    .rs1       (rs1),
    .rs2       (rs2),
    .rd        (rd),
    .rd_data   (rd_data),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data)
  );

  rv_alu u_alu (
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .imm        (imm),
    .pc         (pc),
    .funct3     (funct3),
    .alt_op     (alt_op),
    .use_imm    (use_imm),
    .use_pc     (use_pc),
    .arith_only (arith_only),
    .alu_result (alu_result)
  );

  rv_branch u_branch (
    .clk       (clk),
    .reset     (reset),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .imm       (imm),
    .funct3    (funct3),
    .is_branch (is_branch),
    .is_jal    (is_jal),
    .is_jalr   (is_jalr),
    .pc        (pc),
    .link      (link),
    .target    (target)
  );

  rv_mem_wb u_mem_wb (
    .alu_result (alu_result),
    .link       (link),
    .target     (target),
    .rs2_data   (rs2_data),
    .dmem_rdata (dmem_rdata),
    .funct3     (funct3),
    .mem_write  (mem_write),
    .wb_sel     (wb_sel),
    .rd_data    (rd_data),
    .dmem_wdata (dmem_wdata),
    .dmem_wmask (dmem_wmask)
  );

  assign imem_addr  = pc;
  assign dmem_addr  = alu_result;  // rs1 + offset for loads and stores
  assign dmem_read  = mem_read;
  assign dmem_write = mem_write;

endmodule

`default_nettype wire

// ==== rv_mem_wb.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_mem_wb import rv_pkg::*; (
  input  logic [xlen-1:0]   alu_result,
  input  logic [xlen-1:0]   link,
  input  logic [xlen-1:0]   target,
  input  logic [xlen-1:0]   rs2_data,
  input  logic [xlen-1:0]   dmem_rdata,
  input  logic [2:0]        funct3,
  input  logic              mem_write,
  input  wb_sel_t           wb_sel,
  output logic [xlen-1:0]   rd_data,
  output logic [xlen-1:0]   dmem_wdata,
  output logic [strb_w-1:0] dmem_wmask
);

  logic [1:0]        offset;
  logic [xlen-1:0]   shifted;
  logic [7:0]        load_byte;
  logic [15:0]       load_half;
  logic [xlen-1:0]   load_data;
  logic [strb_w-1:0] size_mask;
  logic              access;

  assign offset = alu_result[1:0];

  // move the addressed lane down to bit 0
  assign shifted   = dmem_rdata >> {offset, 3'b000};
  assign load_byte = shifted[7:0];
  assign load_half = shifted[15:0];

  always_comb begin
    case (funct3)
      f3_b:    load_data = {{24{load_byte[7]}}, load_byte};
      f3_h:    load_data = {{16{load_half[15]}}, load_half};
      f3_bu:   load_data = {24'd0, load_byte};
      f3_hu:   load_data = {16'd0, load_half};
      default: load_data = dmem_rdata;  // lw
    endcase
  end

  // store data replicated across lanes, mask picks the live ones
  always_comb begin
    case (funct3[1:0])
      2'b00: begin
        dmem_wdata = {4{rs2_data[7:0]}};
        size_mask  = 4'b0001 << offset;
      end
      2'b01: begin
        dmem_wdata = {2{rs2_data[15:0]}};
        size_mask  = 4'b0011 << {offset[1], 1'b0};
      end
      default: begin
        dmem_wdata = rs2_data;
        size_mask  = 4'b1111;
      end
    endcase
  end

  assign dmem_wmask = mem_write ? size_mask : '0;

  always_comb begin
    case (wb_sel)
      wb_load:   rd_data = load_data;
      wb_link:   rd_data = link;
      wb_target: rd_data = target;
      default:   rd_data = alu_result;  // also lui, rs1 forced to x0
    endcase
  end

  assign access = mem_write || (wb_sel == wb_load);

  always_comb begin
    if (access) begin
      assert (funct3[1:0] != 2'b01 || !offset[0])
        else $error("mem_wb: misaligned halfword access at %h", alu_result);
      assert (funct3[1:0] != 2'b10 || offset == 2'b00)
        else $error("mem_wb: misaligned word access at %h", alu_result);
    end
  end

endmodule

`default_nettype wire

// ==== rv_branch.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_branch import rv_pkg::*; (
  input  logic            clk,
  input  logic            reset,
  input  logic [xlen-1:0] rs1_data,
  input  logic [xlen-1:0] rs2_data,
  input  logic [xlen-1:0] imm,
  input  logic [2:0]      funct3,
  input  logic            is_branch,
  input  logic            is_jal,
  input  logic            is_jalr,
  output logic [xlen-1:0] pc,
  output logic [xlen-1:0] link,
  output logic [xlen-1:0] target
);

  logic [xlen:0]   diff;  // top bit is the borrow
  logic            eq;
  logic            lt;
  logic            ltu;
  logic            ovf;
  logic            taken;
  logic            redirect;
  logic [xlen-1:0] base;
  logic [xlen-1:0] sum;
  logic [xlen-1:0] next_pc;

  // rs1 - rs2 gives all three compare flags
  assign diff = {1'b0, rs1_data} - {1'b0, rs2_data};
  assign eq   = diff[xlen-1:0] == '0;
  assign ltu  = diff[xlen];
  assign ovf  = (rs1_data[xlen-1] != rs2_data[xlen-1]) &&
                (diff[xlen-1] != rs1_data[xlen-1]);
  assign lt   = diff[xlen-1] ^ ovf;

  always_comb begin
    case (funct3)
      f3_beq:  taken = eq;
      f3_bne:  taken = !eq;
      f3_blt:  taken = lt;
      f3_bge:  taken = !lt;
      f3_bltu: taken = ltu;
      f3_bgeu: taken = !ltu;
      default: taken = 1'b0;  // reserved encodings fall through
    endcase
  end

  // jump target adder
  assign base   = is_jalr ? rs1_data : pc;
  assign sum    = base + imm;
  assign target = is_jalr ? {sum[xlen-1:1], 1'b0} : sum;
  assign link   = pc + xlen'(4);

  assign redirect = (is_branch && taken) || is_jal || is_jalr;
  assign next_pc  = redirect ? target : link;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= reset_pc;
    end else begin
      pc <= next_pc;
    end
  end

  // a misaligned jump target would show up here one edge later
  assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
    else $error("branch: pc not word aligned, pc %h", pc);

endmodule

`default_nettype wire

// ==== rv_alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_alu import rv_pkg::*; (
  input  logic [xlen-1:0] rs1_data,
  input  logic [xlen-1:0] rs2_data,
  input  logic [xlen-1:0] imm,
  input  logic [xlen-1:0] pc,
  input  logic [2:0]      funct3,
  input  logic            alt_op,
  input  logic            use_imm,
  input  logic            use_pc,
  input  logic            arith_only,
  output logic [xlen-1:0] alu_result
);

  logic [xlen-1:0] op_a;
  logic [xlen-1:0] op_b;
  logic [xlen-1:0] sum;
  logic [xlen-1:0] diff;
  logic [4:0]      shamt;
  logic            sub_op;
  logic            lt;
  logic            ltu;

  assign op_a  = use_pc ? pc : rs1_data;   // auipc
  assign op_b  = use_imm ? imm : rs2_data;
  assign shamt = op_b[4:0];

  assign sum    = op_a + op_b;
  assign diff   = op_a - op_b;
  assign sub_op = alt_op && !use_imm;  // addi has no subtract form

  assign lt  = $signed(op_a) < $signed(op_b);
  assign ltu = op_a < op_b;

  always_comb begin
    alu_result = sum;  // loads, stores, lui, auipc
    if (!arith_only) begin
      case (funct3)
        f3_add:  alu_result = sub_op ? diff : sum;
        f3_sll:  alu_result = op_a << shamt;
        f3_slt:  alu_result = {{(xlen - 1){1'b0}}, lt};
        f3_sltu: alu_result = {{(xlen - 1){1'b0}}, ltu};
        f3_xor:  alu_result = op_a ^ op_b;
        f3_sr:   alu_result = alt_op ? $unsigned($signed(op_a) >>> shamt) : op_a >> shamt;
        f3_or:   alu_result = op_a | op_b;
        f3_and:  alu_result = op_a & op_b;
        default: alu_result = sum;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== rv_regfile.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_regfile import rv_pkg::*; (
  input  logic                  clk,
  input  logic                  reg_write,
  input  logic [reg_addr_w-1:0] rs1,
  input  logic [reg_addr_w-1:0] rs2,
  input  logic [reg_addr_w-1:0] rd,
  input  logic [xlen-1:0]       rd_data,
  output logic [xlen-1:0]       rs1_data,
  output logic [xlen-1:0]       rs2_data
);

  logic [xlen-1:0] regs [0:(1 << reg_addr_w) - 1];

  // x0 is never written
  always_ff @(posedge clk) begin
    if (reg_write && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

  // async reads, x0 forced to zero
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// ==== rv_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_decode import rv_pkg::*; (
  input  logic                  reset,
  input  logic [xlen-1:0]       inst,
  output logic [reg_addr_w-1:0] rs1,
  output logic [reg_addr_w-1:0] rs2,
  output logic [reg_addr_w-1:0] rd,
  output logic [xlen-1:0]       imm,
  output logic [2:0]            funct3,
  output logic                  alt_op,
  output logic                  use_imm,
  output logic                  use_pc,
  output logic                  arith_only,
  output logic                  is_branch,
  output logic                  is_jal,
  output logic                  is_jalr,
  output logic                  mem_read,
  output logic                  mem_write,
  output logic                  reg_write,
  output wb_sel_t               wb_sel
);

  logic [6:0]      opcode;
  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_s;
  logic [xlen-1:0] imm_b;
  logic [xlen-1:0] imm_u;
  logic [xlen-1:0] imm_j;
  logic            is_load;
  logic            is_store;
  logic            is_shift_imm;

  assign opcode = inst[6:0];
  assign rs1    = (opcode == op_lui) ? '0 : inst[19:15];  // lui adds imm to x0
  assign rs2    = inst[24:20];
  assign rd     = inst[11:7];
  assign funct3 = inst[14:12];
  assign alt_op = inst[30];  // funct7 bit 5

  // immediate formats
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'h000};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  assign is_shift_imm = (opcode == op_imm) && (funct3 == f3_sll || funct3 == f3_sr);

  always_comb begin
    case (opcode)
      op_imm:           imm = is_shift_imm ? {27'd0, inst[24:20]} : imm_i;  // shamt only
      op_load, op_jalr: imm = imm_i;
      op_store:         imm = imm_s;
      op_branch:        imm = imm_b;
      op_lui, op_auipc: imm = imm_u;
      op_jal:           imm = imm_j;
      default:          imm = '0;
    endcase
  end

  assign is_load   = opcode == op_load;
  assign is_store  = opcode == op_store;
  assign is_branch = opcode == op_branch;
  assign is_jal    = opcode == op_jal;
  assign is_jalr   = opcode == op_jalr;

  assign use_imm    = (opcode != op_r) && !is_branch;
  assign use_pc     = opcode == op_auipc;
  assign arith_only = is_load || is_store || (opcode == op_lui) || use_pc;  // plain add

  // no side effects while reset is held
  assign mem_read  = !reset && is_load;
  assign mem_write = !reset && is_store;
  assign reg_write = !reset &&
                     (opcode inside {op_r, op_imm, op_load, op_jal, op_jalr, op_lui, op_auipc});

  always_comb begin
    case (opcode)
      op_load:         wb_sel = wb_load;
      op_jal, op_jalr: wb_sel = wb_link;
      op_auipc:        wb_sel = wb_target;  // branch unit adder gives pc+imm
      default:         wb_sel = wb_alu;
    endcase
  end

  always_comb begin
    assert (!(mem_read && mem_write))
      else $error("decode: load and store enabled together, inst %h", inst);
  end

endmodule

`default_nettype wire

// ==== rv_pkg.sv ====
`default_nettype none

package rv_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;
  localparam int strb_w     = xlen / 8;  // one mask bit per byte lane

  localparam logic [xlen-1:0] reset_pc = 32'h8000_0000;

  // base opcodes, inst[6:0]
  localparam logic [6:0] op_r      = 7'b011_0011;
  localparam logic [6:0] op_imm    = 7'b001_0011;
  localparam logic [6:0] op_load   = 7'b000_0011;
  localparam logic [6:0] op_store  = 7'b010_0011;
  localparam logic [6:0] op_branch = 7'b110_0011;
  localparam logic [6:0] op_jal    = 7'b110_1111;
  localparam logic [6:0] op_jalr   = 7'b110_0111;
  localparam logic [6:0] op_lui    = 7'b011_0111;
  localparam logic [6:0] op_auipc  = 7'b001_0111;

  // alu funct3
  localparam logic [2:0] f3_add  = 3'b000;  // add, sub
  localparam logic [2:0] f3_sll  = 3'b001;
  localparam logic [2:0] f3_slt  = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor  = 3'b100;
  localparam logic [2:0] f3_sr   = 3'b101;  // srl, sra
  localparam logic [2:0] f3_or   = 3'b110;
  localparam logic [2:0] f3_and  = 3'b111;

  // branch funct3
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  // load/store size
  localparam logic [2:0] f3_b  = 3'b000;
  localparam logic [2:0] f3_h  = 3'b001;
  localparam logic [2:0] f3_w  = 3'b010;
  localparam logic [2:0] f3_bu = 3'b100;
  localparam logic [2:0] f3_hu = 3'b101;

  // register writeback source
  typedef enum logic [1:0] {
    wb_alu    = 2'd0,
    wb_load   = 2'd1,
    wb_link   = 2'd2,  // pc+4
    wb_target = 2'd3   // pc+imm
  } wb_sel_t;

endpackage

`default_nettype wire
